//--- src/gctr_pkg.sv
// Shared AES-GCTR types, configuration struct, increment constants, S-box and round function.
`default_nettype none

package gctr_pkg;

    typedef logic [7:0]   byte_t;     // One AES state byte.
    typedef logic [127:0] block_t;    // Counter block or text block.
    typedef logic [1:0]   inc_mode_t; // Counter increment width select.

    // Increment widths; value 3 falls back to the GCM rule.
    localparam inc_mode_t INC_MODE_32  = 2'd0; // GCM inc32.
    localparam inc_mode_t INC_MODE_64  = 2'd1;
    localparam inc_mode_t INC_MODE_128 = 2'd2;

    // Up to 15 round keys plus counter and mode words.
    localparam int CFG_ADDR_W = 5;

    // Static configuration seen by the GCTR core.
    typedef struct packed {
        block_t    initial_counter; // Counter block reloaded on sop.
        inc_mode_t inc_mode;        // Increment width.
    } gctr_cfg_t;

    // Forward S-box with entry 0 in the leftmost byte.
    localparam byte_t [0:255] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // GF(2^8) multiply by two.
    function automatic byte_t xtime_f(input byte_t value);
        return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
    endfunction

    // One full AES round. Byte 0 is the MSB byte, columns are 4 bytes each.
    function automatic block_t aes_round_f(
        input block_t state,
        input block_t round_key,
        input logic   last_round
    );
        byte_t  sub   [16];
        byte_t  shift [16];
        byte_t  a0;
        byte_t  a1;
        byte_t  a2;
        byte_t  a3;
        block_t result;
        int     k;
        int     r;
        int     c;
        for (k = 0; k < 16; k++)
        begin
            sub[k] = SBOX[state[127-8*k -: 8]]; // SubBytes.
        end
        // Row r rotates left by r columns in ShiftRows.
        for (c = 0; c < 4; c++)
        begin
            for (r = 0; r < 4; r++)
            begin
                shift[r+4*c] = sub[r+4*((c+r)%4)];
            end
        end
        for (c = 0; c < 4; c++)
        begin
            a0 = shift[4*c];
            a1 = shift[4*c+1];
            a2 = shift[4*c+2];
            a3 = shift[4*c+3];
            if (last_round)
            begin
                result[127-32*c -: 32] = {a0, a1, a2, a3}; // No MixColumns.
            end
            else
            begin
                result[127-32*c -: 32] = {
                    xtime_f(a0) ^ xtime_f(a1) ^ a1 ^ a2 ^ a3,
                    a0 ^ xtime_f(a1) ^ xtime_f(a2) ^ a2 ^ a3,
                    a0 ^ a1 ^ xtime_f(a2) ^ xtime_f(a3) ^ a3,
                    xtime_f(a0) ^ a0 ^ a1 ^ a2 ^ xtime_f(a3)
                };
            end
        end
        return result ^ round_key; // AddRoundKey.
    endfunction

endpackage

`default_nettype wire

//--- src/aes_round_ladder_xor_data.sv
// AES cipher pipeline for one block, one register per round, output XORed with a data block.
`timescale 1ns/1ps
`default_nettype none

module aes_round_ladder_xor_data
    import gctr_pkg::*;
#(
    parameter int N_ROUNDS = 14
)
(
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire block_t              i_state,            // Block to encrypt.
    input  wire block_t              i_data,             // Block XORed onto the cipher output.
    input  wire block_t [N_ROUNDS:0] i_round_key_vector, // Key k at index k.
    input  wire logic                i_valid,
    output block_t                   o_state,            // Raw cipher output.
    output block_t                   o_data,             // Cipher output XOR data.
    output logic                     o_valid
);

    block_t                    round_in [N_ROUNDS]; // Input to each round.
    block_t                    round_q  [N_ROUNDS]; // Registered round outputs.
    block_t [N_ROUNDS-1:0]     data_pipe;           // Data rides beside the state.
    logic   [N_ROUNDS-1:0]     valid_pipe;

    genvar g;
    generate
        for (g = 0; g < N_ROUNDS; g++)
        begin : gen_round
            if (g == 0)
            begin : gen_first
                assign round_in[g] = i_state ^ i_round_key_vector[0]; // Initial AddRoundKey.
            end
            else
            begin : gen_chain
                assign round_in[g] = round_q[g-1];
            end
            always_ff @(posedge i_clock)
            begin
                round_q[g] <= aes_round_f(round_in[g], i_round_key_vector[g+1],
                                          g == N_ROUNDS - 1);
            end
        end
    endgenerate

    // Data delay line beside the round registers.
    always_ff @(posedge i_clock)
    begin
        data_pipe <= {data_pipe[N_ROUNDS-2:0], i_data};
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[N_ROUNDS-2:0], i_valid}; // Same depth as rounds.
    end

    assign o_state = round_q[N_ROUNDS-1];
    assign o_data  = round_q[N_ROUNDS-1] ^ data_pipe[N_ROUNDS-1];
    assign o_valid = valid_pipe[N_ROUNDS-1];

    // Output beat lines up with its input beat N_ROUNDS edges later.
    a_valid_latency : assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid == $past(i_valid, N_ROUNDS));

endmodule

`default_nettype wire

//--- src/gctr_function_n_blocks_xor_data_shared.sv
// GCTR core that ciphers N_BLOCKS chained counter blocks per beat and XORs them with plaintext.
`timescale 1ns/1ps
`default_nettype none

module gctr_function_n_blocks_xor_data_shared
    import gctr_pkg::*;
#(
    parameter int N_ROUNDS = 14,
    parameter int N_BLOCKS = 2
)
(
    input  wire logic                               i_clock,
    input  wire logic                               i_reset,
    input  wire logic [N_BLOCKS*$bits(block_t)-1:0] i_plaintext_words_x, // Block 0 in low bits.
    input  wire block_t [N_ROUNDS:0]                i_round_key_vector,
    input  wire gctr_cfg_t                          i_cfg,
    input  wire logic                               i_sop,               // Reload counter.
    input  wire logic                               i_sop_pre,           // Raw AES beat.
    input  wire logic [N_BLOCKS*$bits(block_t)-1:0] i_pre_blocks,
    input  wire logic                               i_valid,
    output logic      [N_BLOCKS*$bits(block_t)-1:0] o_ciphertext_words_y,
    output logic                                    o_valid
);

    localparam int NB_BLOCK = $bits(block_t);

    block_t              counter_chain [N_BLOCKS+1]; // Counter per block plus the carry-out.
    block_t              counter_saved;              // Next counter for the following beat.
    logic [N_BLOCKS-1:0] valid_bus;

    // Counter increment over the field chosen by the mode.
    function automatic block_t inc_block_f(input block_t value, input inc_mode_t mode);
        case (mode)
            INC_MODE_64:  return {value[127:64], value[63:0] + 64'd1};
            INC_MODE_128: return value + 128'd1;
            default:      return {value[127:32], value[31:0] + 32'd1}; // GCM inc32.
        endcase
    endfunction

    assign counter_chain[0] = i_sop ? i_cfg.initial_counter : counter_saved;

    genvar g;
    generate
        for (g = 0; g < N_BLOCKS; g++)
        begin : gen_block
            block_t ladder_state;
            block_t ladder_data;

            // Pre-block beat ciphers the given block against zero data.
            assign ladder_state = i_sop_pre ? block_t'(i_pre_blocks[g*NB_BLOCK +: NB_BLOCK])
                                            : counter_chain[g];
            assign ladder_data  = i_sop_pre ? '0
                                            : block_t'(i_plaintext_words_x[g*NB_BLOCK +: NB_BLOCK]);
            assign counter_chain[g+1] = inc_block_f(counter_chain[g], i_cfg.inc_mode);

            aes_round_ladder_xor_data #(
                .N_ROUNDS           (N_ROUNDS)
            ) u_ladder (
                .i_clock            (i_clock),
                .i_reset            (i_reset),
                .i_state            (ladder_state),
                .i_data             (ladder_data),
                .i_round_key_vector (i_round_key_vector),
                .i_valid            (i_valid | i_sop_pre),
                .o_state            (),  // Raw cipher not needed here.
                .o_data             (o_ciphertext_words_y[g*NB_BLOCK +: NB_BLOCK]),
                .o_valid            (valid_bus[g])
            );
        end
    endgenerate

    // All ladders run in lockstep.
    assign o_valid = &valid_bus;

    // Carry the chain forward on text beats only.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            counter_saved <= '0;
        else if (i_valid)
            counter_saved <= counter_chain[N_BLOCKS];
    end

    // Pre-block and text beats share the ladders, so they must not collide.
    a_no_pre_with_text : assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_sop_pre && i_valid));

endmodule

`default_nettype wire

//--- src/gctr_config_regs.sv
// Configuration registers for round keys, initial counter and increment mode, written by strobe.
`timescale 1ns/1ps
`default_nettype none

module gctr_config_regs
    import gctr_pkg::*;
#(
    parameter int N_ROUNDS = 14
)
(
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire logic                  i_cfg_write,        // One-cycle write strobe.
    input  wire logic [CFG_ADDR_W-1:0] i_cfg_addr,
    input  wire block_t                i_cfg_data,
    output block_t [N_ROUNDS:0]        o_round_key_vector,
    output gctr_cfg_t                  o_cfg
);

    // Control words sit right after the last key.
    localparam logic [CFG_ADDR_W-1:0] ADDR_LAST_KEY = CFG_ADDR_W'(N_ROUNDS);
    localparam logic [CFG_ADDR_W-1:0] ADDR_COUNTER  = CFG_ADDR_W'(N_ROUNDS + 1);
    localparam logic [CFG_ADDR_W-1:0] ADDR_MODE     = CFG_ADDR_W'(N_ROUNDS + 2);

    block_t [N_ROUNDS:0] key_q; // Expanded key schedule.
    gctr_cfg_t           cfg_q;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            key_q                 <= '0;
            cfg_q.initial_counter <= '0;
            cfg_q.inc_mode        <= INC_MODE_32; // GCM default.
        end
        else if (i_cfg_write)
        begin
            if (i_cfg_addr <= ADDR_LAST_KEY)
                key_q[i_cfg_addr] <= i_cfg_data;
            else if (i_cfg_addr == ADDR_COUNTER)
                cfg_q.initial_counter <= i_cfg_data;
            else if (i_cfg_addr == ADDR_MODE)
                cfg_q.inc_mode <= inc_mode_t'(i_cfg_data[1:0]); // Low bits only.
        end
    end

    assign o_round_key_vector = key_q;
    assign o_cfg              = cfg_q;

    // Writes outside the map would be silently dropped.
    a_addr_in_map : assert property (@(posedge i_clock) disable iff (i_reset)
        i_cfg_write |-> i_cfg_addr <= ADDR_MODE);

endmodule

`default_nettype wire

//--- src/gctr_top.sv
// GCTR engine top level joining the configuration registers and the counter-mode core.
`timescale 1ns/1ps
`default_nettype none

module gctr_top
    import gctr_pkg::*;
#(
    parameter int N_ROUNDS = 14, // 10, 12 or 14.
    parameter int N_BLOCKS = 2   // Blocks per beat, 1 to 4.
)
(
    input  wire logic                               i_clock,
    input  wire logic                               i_reset,
    input  wire logic                               i_cfg_write,
    input  wire logic [CFG_ADDR_W-1:0]              i_cfg_addr,
    input  wire block_t                             i_cfg_data,
    input  wire logic [N_BLOCKS*$bits(block_t)-1:0] i_plaintext,
    input  wire logic                               i_valid,
    input  wire logic                               i_sop,
    input  wire logic                               i_sop_pre,
    input  wire logic [N_BLOCKS*$bits(block_t)-1:0] i_pre_blocks,
    output logic      [N_BLOCKS*$bits(block_t)-1:0] o_ciphertext,
    output logic                                    o_valid
);

    block_t [N_ROUNDS:0] round_key_vector; // Key schedule to the ladders.
    gctr_cfg_t           cfg;

    gctr_config_regs #(
        .N_ROUNDS           (N_ROUNDS)
    ) u_config_regs (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_cfg_write        (i_cfg_write),
        .i_cfg_addr         (i_cfg_addr),
        .i_cfg_data         (i_cfg_data),
        .o_round_key_vector (round_key_vector),
        .o_cfg              (cfg)
    );

    gctr_function_n_blocks_xor_data_shared #(
        .N_ROUNDS             (N_ROUNDS),
        .N_BLOCKS             (N_BLOCKS)
    ) u_gctr_core (
        .i_clock              (i_clock),
        .i_reset              (i_reset),
        .i_plaintext_words_x  (i_plaintext),
        .i_round_key_vector   (round_key_vector),
        .i_cfg                (cfg),
        .i_sop                (i_sop),
        .i_sop_pre            (i_sop_pre),
        .i_pre_blocks         (i_pre_blocks),
        .i_valid              (i_valid),
        .o_ciphertext_words_y (o_ciphertext),
        .o_valid              (o_valid)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// Free-running testbench clock source; instantiate once and take the clock from o_clock.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0 // Full clock period.
)
(
    output logic o_clock
);

    initial
    begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clock = ~o_clock; // Half period per phase.
    end

endmodule

`default_nettype wire

//--- tests/gctr_tb.sv
// Self-checking testbench for gctr_top; a reference model queues expected beats for assertions.
`timescale 1ns/1ps
`default_nettype none

module gctr_tb
    import gctr_pkg::*;
;

    localparam int N_ROUNDS    = 14;
    localparam int N_BLOCKS    = 2;
    localparam int NB_DATA     = N_BLOCKS * $bits(block_t);
    localparam int DRIVE_DELAY = 1;       // ns after the rising edge.
    localparam int DRAIN_LIMIT = N_ROUNDS + 4;
    // Config writes plus data and pre-block beats driven below.
    localparam int N_CFG_WRITES    = 28;
    localparam int N_DATA_BEATS    = 19;
    localparam int TOTAL_BEATS     = N_CFG_WRITES + N_DATA_BEATS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 2 + N_ROUNDS + 50;

    logic                  clock;
    logic                  i_reset;
    logic                  i_cfg_write;
    logic [CFG_ADDR_W-1:0] i_cfg_addr;
    block_t                i_cfg_data;
    logic [NB_DATA-1:0]    i_plaintext;
    logic                  i_valid;
    logic                  i_sop;
    logic                  i_sop_pre;
    logic [NB_DATA-1:0]    i_pre_blocks;
    logic [NB_DATA-1:0]    o_ciphertext;
    logic                  o_valid;

    integer seed = 32'hc69a_75cc;

    // Reference model state.
    block_t    model_keys [0:N_ROUNDS];
    block_t    model_counter;         // Initial counter block.
    inc_mode_t model_mode;
    block_t    model_saved;           // Chain carried between beats.

    logic [NB_DATA-1:0] exp_q [$];    // Expected output beats with the oldest first.
    logic [NB_DATA-1:0] exp_head;
    logic               exp_avail;

    int value_errors;
    int timing_errors;
    int missing_errors;

    tb_clock_gen #(
        .PERIOD_NS (4.0)
    ) u_clock (
        .o_clock (clock)
    );

    gctr_top #(
        .N_ROUNDS     (N_ROUNDS),
        .N_BLOCKS     (N_BLOCKS)
    ) dut0 (
        .i_clock      (clock),
        .i_reset      (i_reset),
        .i_cfg_write  (i_cfg_write),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .i_plaintext  (i_plaintext),
        .i_valid      (i_valid),
        .i_sop        (i_sop),
        .i_sop_pre    (i_sop_pre),
        .i_pre_blocks (i_pre_blocks),
        .o_ciphertext (o_ciphertext),
        .o_valid      (o_valid)
    );

    // Full cipher from the model key schedule.
    function automatic block_t aes_encrypt(input block_t blk);
        block_t st;
        int     r;
        st = blk ^ model_keys[0]; // Initial AddRoundKey.
        for (r = 1; r <= N_ROUNDS; r++)
        begin
            st = aes_round_f(st, model_keys[r], r == N_ROUNDS);
        end
        return st;
    endfunction

    // Counter step; only the selected low field rolls over.
    function automatic block_t next_counter(input block_t c, input inc_mode_t m);
        block_t n;
        n = c;
        if (m == INC_MODE_128)
            n = c + 128'd1;
        else if (m == INC_MODE_64)
            n[63:0] = c[63:0] + 64'd1;
        else
            n[31:0] = c[31:0] + 32'd1; // Mode 0 and mode 3.
        return n;
    endfunction

    task automatic rand_block(output block_t blk);
        blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic refresh_head();
        exp_avail = exp_q.size() > 0;
        exp_head  = exp_avail ? exp_q[0] : '0;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    task automatic cfg_write(input int addr, input block_t data);
        i_cfg_write = 1'b1;
        i_cfg_addr  = CFG_ADDR_W'(addr);
        i_cfg_data  = data;
        if (addr <= N_ROUNDS)
            model_keys[addr] = data;
        else if (addr == N_ROUNDS + 1)
            model_counter = data;
        else
            model_mode = inc_mode_t'(data[1:0]);
        next_cycle();
        i_cfg_write = 1'b0;
    endtask

    // One plaintext beat; expected = text XOR AES(counter) per block.
    task automatic text_beat(input logic sop);
        logic [NB_DATA-1:0] pt;
        logic [NB_DATA-1:0] expect_beat;
        block_t             blk;
        block_t             ctr;
        int                 b;
        ctr = sop ? model_counter : model_saved;
        for (b = 0; b < N_BLOCKS; b++)
        begin
            rand_block(blk);
            pt[b*128 +: 128]          = blk;
            expect_beat[b*128 +: 128] = blk ^ aes_encrypt(ctr);
            ctr                       = next_counter(ctr, model_mode);
        end
        model_saved = ctr; // Carry-out for the next beat.
        exp_q.push_back(expect_beat);
        refresh_head();
        i_valid     = 1'b1;
        i_sop       = sop;
        i_plaintext = pt;
        next_cycle();
        i_valid = 1'b0;
        i_sop   = 1'b0;
    endtask

    // Raw AES of caller blocks with the chain untouched.
    task automatic pre_beat();
        logic [NB_DATA-1:0] pre;
        logic [NB_DATA-1:0] expect_beat;
        block_t             blk;
        int                 b;
        for (b = 0; b < N_BLOCKS; b++)
        begin
            rand_block(blk);
            pre[b*128 +: 128]         = blk;
            expect_beat[b*128 +: 128] = aes_encrypt(blk);
        end
        exp_q.push_back(expect_beat);
        refresh_head();
        i_sop_pre    = 1'b1;
        i_pre_blocks = pre;
        next_cycle();
        i_sop_pre = 1'b0;
    endtask

    // Wait a bounded time for all queued beats to come out.
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT)
        begin
            next_cycle();
            n++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            missing_errors++;
            $display("o_valid never came for %0d expected beats at %0t", exp_q.size(), $time);
            exp_q.delete();
            refresh_head();
        end
    endtask

    // Retire the head on each output beat.
    always @(posedge clock)
    begin
        if (!i_reset && o_valid && exp_q.size() > 0)
        begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_ciphertext : assert property (@(posedge clock) disable iff (i_reset)
        (o_valid && exp_avail) |-> o_ciphertext == exp_head)
    else
    begin
        value_errors++;
        $display("[ERROR] %0t o_ciphertext expected %h got %h", $time,
                 $sampled(exp_head), $sampled(o_ciphertext));
    end

    a_no_extra_beat : assert property (@(posedge clock) disable iff (i_reset)
        o_valid |-> exp_avail)
    else
    begin
        timing_errors++;
        $display("Unexpected o_valid with no beat outstanding at %0t", $time);
    end

    // Fixed latency from any input beat.
    a_latency : assert property (@(posedge clock) disable iff (i_reset)
        o_valid == $past(i_valid || i_sop_pre, N_ROUNDS))
    else
    begin
        timing_errors++;
        $display("o_valid missing or early, not %0d cycles after its input beat, at %0t",
                 N_ROUNDS, $time);
    end

    initial
    begin
        block_t    blk;
        inc_mode_t modes [4];
        int        k;
        modes = '{INC_MODE_32, INC_MODE_64, INC_MODE_128, 2'd3};
        value_errors   = 0;
        timing_errors  = 0;
        missing_errors = 0;
        i_reset      = 1'b1;
        i_cfg_write  = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_data   = '0;
        i_plaintext  = '0;
        i_valid      = 1'b0;
        i_sop        = 1'b0;
        i_sop_pre    = 1'b0;
        i_pre_blocks = '0;
        for (k = 0; k <= N_ROUNDS; k++)
        begin
            model_keys[k] = '0; // Reset values of the DUT.
        end
        model_counter = '0;
        model_mode    = INC_MODE_32;
        model_saved   = '0;
        refresh_head();
        repeat (3) @(posedge clock);
        #(DRIVE_DELAY);
        i_reset = 1'b0;
        repeat (4) next_cycle(); // Idle, o_valid must stay low.

        for (k = 0; k <= N_ROUNDS; k++)
        begin
            rand_block(blk);
            cfg_write(k, blk);
        end
        rand_block(blk);
        cfg_write(N_ROUNDS + 1, blk);
        cfg_write(N_ROUNDS + 2, block_t'(INC_MODE_32));

        // Back-to-back beats, then chain across gaps and a pre-block.
        text_beat(1'b1);
        text_beat(1'b0);
        text_beat(1'b0);
        text_beat(1'b0);
        repeat (2) next_cycle();
        text_beat(1'b0);
        text_beat(1'b0);
        next_cycle();
        pre_beat();
        next_cycle();
        text_beat(1'b0);
        wait_drain();

        // Counter wrap per mode with the low 64 bits all ones.
        for (k = 0; k < 4; k++)
        begin
            cfg_write(N_ROUNDS + 2, block_t'(modes[k]));
            rand_block(blk);
            blk[63:0] = '1;
            cfg_write(N_ROUNDS + 1, blk);
            text_beat(1'b1);
            text_beat(1'b0);
        end
        wait_drain();

        // New key and counter between packets.
        rand_block(blk);
        cfg_write(5, blk);
        rand_block(blk);
        cfg_write(N_ROUNDS + 1, blk);
        cfg_write(N_ROUNDS + 2, block_t'(INC_MODE_32));
        text_beat(1'b1);
        text_beat(1'b0);
        text_beat(1'b0);
        wait_drain();
        repeat (2) next_cycle();

        $display("Errors: value %0d, timing %0d, missing %0d",
                 value_errors, timing_errors, missing_errors);
        if (value_errors + timing_errors + missing_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Hard stop if the stimulus stalls.
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles before the stimulus finished",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/gctr_pkg.sv
src/aes_round_ladder_xor_data.sv
src/gctr_function_n_blocks_xor_data_shared.sv
src/gctr_config_regs.sv
src/gctr_top.sv
tests/tb_clock_gen.sv
tests/gctr_tb.sv
